/* src.f */
design/mips_pkg.sv
design/dmem_if.sv
design/mips_decoder.sv
design/mips_alu.sv
design/mips_reg_file.sv
design/mips_pc_unit.sv
design/mips_load_store.sv
design/mips_data_mem.sv
design/mips_instr_mem.sv
design/mips_core.sv
verification/tb_mips_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mips_core
FILELIST  = src.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_mips_core.sv */
`timescale 1ns/100ps

module tb_mips_core import mips_pkg::*; ();

    localparam int CLK_HALF   = 2;
    localparam int RST_CYCLES = 4;
    localparam int MAX_CYCLES = 2000;  // Tests take about 650 cycles

    logic              mem_debug_clk_gate;
    logic              HW_RSTn;
    logic [DATA_W-1:0] din;
    logic [DATA_W-1:0] addr;
    logic [1:0]        debug_func;
    logic              debug_we;
    logic              mem_debug;
    logic [DATA_W-1:0] dout;

    int unsigned       cycle_count = 0;
    int                seed;
    logic [DATA_W-1:0] prog [$];

    // Reference model state
    logic [DATA_W-1:0] ref_regs [32];
    logic [DATA_W-1:0] ref_dmem [DMEM_DEPTH];
    logic              dm_known [DMEM_DEPTH];  // Words with defined contents
    logic [DATA_W-1:0] ref_imem [IMEM_DEPTH];
    logic [DATA_W-1:0] ref_pc;
    logic              ref_br_pend;
    logic [15:0]       ref_br_off;

    mips_core UUT (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .din                (din),
        .addr               (addr),
        .debug_func         (debug_func),
        .debug_we           (debug_we),
        .mem_debug          (mem_debug),
        .dout               (dout)
    );

    always #CLK_HALF mem_debug_clk_gate = ~mem_debug_clk_gate;

    always @(posedge mem_debug_clk_gate) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            abort_simulation();
        end
    end

    task automatic abort_simulation();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        if (actual !== expected) begin
            $display("Error: %s expected %h, got %h", name, expected, actual);
            abort_simulation();
        end
    endtask

    function automatic logic [DATA_W-1:0] random_word();
        return $random(seed);
    endfunction

    function automatic logic [31:0] r_type_word(input funct_e fn, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd,
                                                input logic [4:0] sh);
        return {OP_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type_word(input opcode_e op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic debug_write(input debug_target_e tgt, input int index,
                               input logic [DATA_W-1:0] data);
        @(negedge mem_debug_clk_gate);
        mem_debug  = 1'b1;
        debug_func = tgt;
        addr       = (tgt == DBG_MR) ? index : index * 4;  // Memories take byte addresses
        din        = data;
        debug_we   = 1'b1;
        @(posedge mem_debug_clk_gate);
    endtask

    task automatic debug_read(input debug_target_e tgt, input int index,
                              input logic [DATA_W-1:0] expected, input string name);
        @(negedge mem_debug_clk_gate);
        mem_debug  = 1'b1;
        debug_we   = 1'b0;
        debug_func = tgt;
        addr       = (tgt == DBG_MR) ? index : index * 4;
        #1;
        check_value(name, dout, expected);
    endtask

    // One instruction of the reference model
    task automatic model_step();
        logic [DATA_W-1:0] iw;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] sx;
        logic [DATA_W-1:0] zx;
        logic [DATA_W-1:0] ea;
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] res;
        logic [DATA_W-1:0] next_pc;
        logic [4:0]        dst;
        logic              wr;
        logic              taken;
        iw      = ref_imem[ref_pc[IMEM_AW+1:2]];
        a       = ref_regs[iw[25:21]];
        b       = ref_regs[iw[20:16]];
        sx      = {{16{iw[15]}}, iw[15:0]};
        zx      = {16'h0000, iw[15:0]};
        ea      = a + sx;
        word    = ref_dmem[ea[DMEM_AW+1:2]];
        res     = '0;
        wr      = 1'b1;
        dst     = iw[20:16];
        taken   = 1'b0;
        // A branch retired last step moves the PC off the delay slot
        if (ref_br_pend) begin
            next_pc = ref_pc + {{14{ref_br_off[15]}}, ref_br_off, 2'b00};
        end else begin
            next_pc = ref_pc + 4;
        end
        case (iw[31:26])
            OP_RTYPE: begin
                dst = iw[15:11];
                case (iw[5:0])
                    FN_ADD, FN_ADDU: res = a + b;
                    FN_SUB, FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  res = b << iw[10:6];
                    FN_SRL:  res = b >> iw[10:6];
                    FN_JR: begin
                        wr = 1'b0;
                        if (!ref_br_pend) begin
                            next_pc = a;
                        end
                    end
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + sx;
            OP_SLTI:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_SLTIU: res = (a < sx) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & zx;
            OP_ORI:   res = a | zx;
            OP_XORI:  res = a ^ zx;
            OP_LUI:   res = {iw[15:0], 16'h0000};
            OP_LB:    res = {{24{word[7]}}, word[7:0]};
            OP_LBU:   res = {24'h000000, word[7:0]};
            OP_LH:    res = {{16{word[15]}}, word[15:0]};
            OP_LHU:   res = {16'h0000, word[15:0]};
            OP_LW:    res = word;
            OP_SB, OP_SH, OP_SW: begin
                wr = 1'b0;
                if (iw[31:26] == OP_SB) begin
                    ref_dmem[ea[DMEM_AW+1:2]] = {word[31:8], b[7:0]};
                end else if (iw[31:26] == OP_SH) begin
                    ref_dmem[ea[DMEM_AW+1:2]] = {word[31:16], b[15:0]};
                end else begin
                    ref_dmem[ea[DMEM_AW+1:2]] = b;
                end
            end
            OP_BEQ, OP_BNE: begin
                wr    = 1'b0;
                taken = (iw[31:26] == OP_BEQ) ? (a == b) : (a != b);
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != 5'd0) begin
            ref_regs[dst] = res;
        end
        if (taken) begin
            ref_br_off = iw[15:0];
        end
        ref_br_pend = taken;
        ref_pc      = next_pc;
    endtask

    task automatic load_program();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            ref_imem[i] = (i < prog.size()) ? prog[i] : '0;  // Zero word acts as NOP
            debug_write(DBG_IM, i, ref_imem[i]);
        end
    endtask

    task automatic preload_regs();
        for (int i = 1; i < 32; i++) begin
            ref_regs[i] = random_word();
            debug_write(DBG_MR, i, ref_regs[i]);
        end
    endtask

    task automatic run_program(input int n);
        ref_pc      = RESET_PC;
        ref_br_pend = 1'b0;
        repeat (n) model_step();
        @(negedge mem_debug_clk_gate);
        debug_we  = 1'b0;
        mem_debug = 1'b0;
        repeat (n) @(posedge mem_debug_clk_gate);
        @(negedge mem_debug_clk_gate);
        mem_debug = 1'b1;
    endtask

    task automatic compare_regs();
        for (int i = 0; i < 32; i++) begin
            debug_read(DBG_MR, i, ref_regs[i], $sformatf("r%0d", i));
        end
    endtask

    task automatic compare_dmem();
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            if (dm_known[i]) begin
                debug_read(DBG_DM, i, ref_dmem[i], $sformatf("dm[%0d]", i));
            end
        end
    endtask

    task automatic debug_round_trip();
        int im_idx [4] = '{0, 7, 19, 31};
        int dm_idx [3] = '{1, 9, 30};
        int mr_idx [4] = '{1, 8, 17, 31};
        foreach (im_idx[k]) begin
            ref_imem[im_idx[k]] = random_word();
            debug_write(DBG_IM, im_idx[k], ref_imem[im_idx[k]]);
        end
        foreach (dm_idx[k]) begin
            ref_dmem[dm_idx[k]] = random_word();
            dm_known[dm_idx[k]] = 1'b1;
            debug_write(DBG_DM, dm_idx[k], ref_dmem[dm_idx[k]]);
        end
        foreach (mr_idx[k]) begin
            ref_regs[mr_idx[k]] = random_word();
            debug_write(DBG_MR, mr_idx[k], ref_regs[mr_idx[k]]);
        end
        foreach (im_idx[k]) begin
            debug_read(DBG_IM, im_idx[k], ref_imem[im_idx[k]], $sformatf("im[%0d]", im_idx[k]));
        end
        compare_dmem();
        foreach (mr_idx[k]) begin
            debug_read(DBG_MR, mr_idx[k], ref_regs[mr_idx[k]], $sformatf("r%0d", mr_idx[k]));
        end
        debug_write(DBG_MR, 0, random_word());
        debug_read(DBG_MR, 0, '0, "r0");
        debug_read(DBG_NONE, 9, '0, "dout target none");
    endtask

    task automatic alu_instructions();
        logic [15:0] imm [7];
        foreach (imm[k]) begin
            imm[k] = 16'(random_word());
        end
        preload_regs();
        prog.delete();
        prog.push_back(r_type_word(FN_ADD,  1, 2, 10, 0));
        prog.push_back(r_type_word(FN_ADDU, 3, 4, 11, 0));
        prog.push_back(r_type_word(FN_SUB,  5, 6, 12, 0));
        prog.push_back(r_type_word(FN_SUBU, 7, 8, 13, 0));
        prog.push_back(r_type_word(FN_AND,  1, 3, 14, 0));
        prog.push_back(r_type_word(FN_OR,   2, 4, 15, 0));
        prog.push_back(r_type_word(FN_XOR,  5, 7, 16, 0));
        prog.push_back(r_type_word(FN_NOR,  6, 8, 17, 0));
        prog.push_back(r_type_word(FN_SLT,  1, 2, 18, 0));
        prog.push_back(r_type_word(FN_SLTU, 3, 4, 19, 0));
        prog.push_back(r_type_word(FN_SLL,  0, 5, 20, 7));
        prog.push_back(r_type_word(FN_SRL,  0, 6, 21, 13));
        prog.push_back(i_type_word(OP_ADDIU, 1, 22, imm[0]));
        prog.push_back(i_type_word(OP_ANDI,  2, 23, imm[1]));
        prog.push_back(i_type_word(OP_ORI,   3, 24, imm[2]));
        prog.push_back(i_type_word(OP_XORI,  4, 25, imm[3]));
        prog.push_back(i_type_word(OP_SLTI,  5, 26, imm[4]));
        prog.push_back(i_type_word(OP_SLTIU, 6, 27, imm[5]));
        prog.push_back(i_type_word(OP_LUI,   0, 28, imm[6]));
        prog.push_back(r_type_word(FN_SLT,  9, 9, 29, 0));    // Equal operands
        prog.push_back(r_type_word(FN_ADD, 10, 11, 30, 0));  // Uses earlier results
        load_program();
        run_program(prog.size());
        compare_regs();
    endtask

    task automatic loads_and_stores();
        preload_regs();
        ref_regs[3][15] = 1'b1;  // Negative half and byte for sign extension
        ref_regs[4][7]  = 1'b1;
        debug_write(DBG_MR, 3, ref_regs[3]);
        debug_write(DBG_MR, 4, ref_regs[4]);
        for (int i = 4; i < 12; i++) begin
            ref_dmem[i] = random_word();
            dm_known[i] = 1'b1;
            debug_write(DBG_DM, i, ref_dmem[i]);
        end
        prog.delete();
        prog.push_back(i_type_word(OP_ADDIU, 0, 1, 16'd16));  // Base at word 4
        prog.push_back(i_type_word(OP_SW,  1, 2, 16'd0));
        prog.push_back(i_type_word(OP_SH,  1, 3, 16'd4));
        prog.push_back(i_type_word(OP_SB,  1, 4, 16'd8));
        prog.push_back(i_type_word(OP_LW,  1, 10, 16'd0));
        prog.push_back(i_type_word(OP_LH,  1, 11, 16'd4));
        prog.push_back(i_type_word(OP_LHU, 1, 12, 16'd4));
        prog.push_back(i_type_word(OP_LB,  1, 13, 16'd8));
        prog.push_back(i_type_word(OP_LBU, 1, 14, 16'd8));
        prog.push_back(i_type_word(OP_LB,  1, 15, 16'd12));
        prog.push_back(i_type_word(OP_ADDIU, 0, 5, 16'd40));
        prog.push_back(i_type_word(OP_LW,  5, 16, 16'hfff8));  // Negative offset
        prog.push_back(i_type_word(OP_LHU, 1, 17, 16'd12));
        load_program();
        run_program(prog.size());
        compare_regs();
        compare_dmem();
    endtask

    task automatic branch_delay_slots();
        preload_regs();
        prog.delete();
        prog.push_back(i_type_word(OP_ADDIU, 0, 1, 16'd5));
        prog.push_back(i_type_word(OP_ADDIU, 0, 2, 16'd5));
        prog.push_back(i_type_word(OP_BEQ,   1, 2, 16'd3));  // Taken, lands on 6
        prog.push_back(i_type_word(OP_ADDIU, 0, 10, 16'd3));
        prog.push_back(i_type_word(OP_ADDIU, 0, 11, 16'd4));
        prog.push_back(i_type_word(OP_ADDIU, 0, 12, 16'd5));
        prog.push_back(i_type_word(OP_BEQ,   1, 0, 16'd2));  // Not taken
        prog.push_back(i_type_word(OP_ADDIU, 0, 13, 16'd7));
        prog.push_back(i_type_word(OP_ADDIU, 0, 14, 16'd8));
        prog.push_back(i_type_word(OP_BNE,   1, 0, 16'd2));  // Taken, lands on 12
        prog.push_back(i_type_word(OP_ADDIU, 0, 15, 16'd10));
        prog.push_back(i_type_word(OP_ADDIU, 0, 16, 16'd11));
        prog.push_back(i_type_word(OP_ADDIU, 0, 17, 16'd12));
        load_program();
        run_program(10);  // Indices 4, 5 and 11 never retire
        compare_regs();
    endtask

    task automatic jump_register();
        preload_regs();
        prog.delete();
        prog.push_back(i_type_word(OP_ADDIU, 0, 1, 16'd20));
        prog.push_back(r_type_word(FN_JR, 1, 0, 0, 0));
        prog.push_back(i_type_word(OP_ADDIU, 0, 10, 16'd2));
        prog.push_back(i_type_word(OP_ADDIU, 0, 11, 16'd3));
        prog.push_back(i_type_word(OP_ADDIU, 0, 12, 16'd4));
        prog.push_back(i_type_word(OP_ADDIU, 0, 13, 16'd5));  // JR target
        prog.push_back(r_type_word(FN_ADDU, 13, 1, 14, 0));
        load_program();
        run_program(4);
        compare_regs();
    endtask

    task automatic reset_restart();
        preload_regs();
        prog.delete();
        for (int i = 0; i < 6; i++) begin
            prog.push_back(i_type_word(OP_ADDIU, 0, 5'(i + 1), 16'(17 * (i + 1))));
        end
        load_program();
        @(negedge mem_debug_clk_gate);
        debug_we  = 1'b0;
        mem_debug = 1'b0;
        repeat (3) @(posedge mem_debug_clk_gate);
        @(negedge mem_debug_clk_gate);
        mem_debug = 1'b1;
        HW_RSTn   = 1'b0;
        repeat (RST_CYCLES) @(negedge mem_debug_clk_gate);
        HW_RSTn = 1'b1;
        for (int i = 0; i < 32; i++) begin
            debug_read(DBG_MR, i, '0, $sformatf("r%0d after reset", i));
            ref_regs[i] = '0;
        end
        load_program();  // Memory contents are undefined after reset
        run_program(prog.size());
        compare_regs();
    endtask

    initial begin
        seed               = 32'hf860;
        mem_debug_clk_gate = 1'b0;
        HW_RSTn            = 1'b0;
        din                = '0;
        addr               = '0;
        debug_func         = DBG_NONE;
        debug_we           = 1'b0;
        mem_debug          = 1'b1;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
            ref_imem[i] = '0;
            ref_dmem[i] = '0;
            dm_known[i] = 1'b0;
        end
        repeat (RST_CYCLES) @(negedge mem_debug_clk_gate);
        HW_RSTn = 1'b1;

        debug_round_trip();
        alu_instructions();
        loads_and_stores();
        branch_delay_slots();
        jump_register();
        reset_restart();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* design/mips_core.sv */
`timescale 1ns/100ps

module mips_core import mips_pkg::*; (
    input  logic              mem_debug_clk_gate,
    input  logic              HW_RSTn,
    input  logic [DATA_W-1:0] din,
    input  logic [DATA_W-1:0] addr,
    input  logic [1:0]        debug_func,
    input  logic              debug_we,
    input  logic              mem_debug,
    output logic [DATA_W-1:0] dout
);

    debug_target_e         dbg_tgt;
    logic                  dbg_im_we, dbg_dm_we, dbg_mr_we;
    logic [DATA_W-1:0]     pc, imem_addr;
    mips_instr_u           instr;
    ctrl_t                 ctrl;
    logic [REG_ADDR_W-1:0] rt_addr, dst_addr, wr_addr;
    logic [DATA_W-1:0]     rs_data, rt_data, wr_data;
    logic [DATA_W-1:0]     op_a, op_b, alu_result, load_data, wb_data;
    wb_sel_e               wb_sel;

    dmem_if dmem_bus ();

    assign dbg_tgt   = debug_target_e'(debug_func);
    assign dbg_im_we = mem_debug && debug_we && (dbg_tgt == DBG_IM);
    assign dbg_dm_we = mem_debug && debug_we && (dbg_tgt == DBG_DM);
    assign dbg_mr_we = mem_debug && debug_we && (dbg_tgt == DBG_MR);

    assign imem_addr = mem_debug ? addr : pc;

    mips_instr_mem u_imem (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .addr               (imem_addr),
        .we                 (dbg_im_we),
        .wdata              (din),
        .rdata              (instr)
    );

    mips_decoder u_dec (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // Debug port borrows the rt read port and the write port
    assign rt_addr  = mem_debug ? addr[REG_ADDR_W-1:0] : instr.r.rt;
    assign dst_addr = ctrl.dst_is_rt ? instr.i.rt : instr.r.rd;
    assign wr_addr  = mem_debug ? addr[REG_ADDR_W-1:0] : dst_addr;
    assign wr_data  = mem_debug ? din : wb_data;

    mips_reg_file u_regs (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .rs_addr            (instr.r.rs),
        .rt_addr            (rt_addr),
        .wr_addr            (wr_addr),
        .wr_data            (wr_data),
        .wr_en              (mem_debug ? dbg_mr_we : ctrl.reg_we),
        .rs_data            (rs_data),
        .rt_data            (rt_data)
    );

    // Shifts move rt by shamt, so rt goes to A and shamt to B
    assign op_a = ctrl.use_shamt ? rt_data : rs_data;

    always_comb begin
        if (ctrl.use_shamt) begin
            op_b = {{(DATA_W-5){1'b0}}, instr.r.shamt};
        end else begin
            case (ctrl.imm_ext)
                IMM_SIGN:  op_b = {{(DATA_W-16){instr.i.imm16[15]}}, instr.i.imm16};
                IMM_ZERO:  op_b = {{(DATA_W-16){1'b0}}, instr.i.imm16};
                IMM_UPPER: op_b = {instr.i.imm16, {(DATA_W-16){1'b0}}};
                default:   op_b = rt_data;
            endcase
        end
    end

    mips_alu u_alu (
        .op     (ctrl.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    mips_pc_unit u_pc (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .HW_RSTn            (HW_RSTn),
        .mem_debug          (mem_debug),
        .ctrl               (ctrl),
        .cond               (alu_result[0]),
        .offset             (instr.i.imm16),
        .rs_data            (rs_data),
        .pc                 (pc)
    );

    mips_load_store u_lsu (
        .mem_debug  (mem_debug),
        .dbg_dm_we  (dbg_dm_we),
        .addr       (addr),
        .din        (din),
        .ctrl       (ctrl),
        .alu_result (alu_result),
        .rt_data    (rt_data),
        .dmem       (dmem_bus.ctrl),
        .load_data  (load_data)
    );

    mips_data_mem u_dmem (
        .mem_debug_clk_gate (mem_debug_clk_gate),
        .dmem               (dmem_bus.mem)
    );

    assign wb_sel  = ctrl.mem_load ? WB_LOAD : WB_ALU;
    assign wb_data = (wb_sel == WB_LOAD) ? load_data : alu_result;

    always_comb begin
        case (dbg_tgt)
            DBG_IM:  dout = instr;
            DBG_DM:  dout = load_data;
            DBG_MR:  dout = rt_data;
            default: dout = '0;
        endcase
    end

endmodule

/* design/mips_instr_mem.sv */
`timescale 1ns/100ps

module mips_instr_mem import mips_pkg::*; (
    input  logic              mem_debug_clk_gate,
    input  logic [DATA_W-1:0] addr,
    input  logic              we,
    input  logic [DATA_W-1:0] wdata,
    output mips_instr_u       rdata
);

    logic [DATA_W-1:0]  mem [IMEM_DEPTH];
    logic [IMEM_AW-1:0] word_idx;

    assign word_idx = addr[IMEM_AW+1:2];

    // Only the back door loads programs
    always_ff @(posedge mem_debug_clk_gate) begin
        if (we) begin
            mem[word_idx] <= wdata;
        end
    end

    assign rdata = mem[word_idx];

endmodule

/* design/mips_data_mem.sv */
`timescale 1ns/100ps

module mips_data_mem import mips_pkg::*; (
    input logic  mem_debug_clk_gate,
    dmem_if.mem  dmem
);

    logic [DATA_W-1:0]  mem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] word_idx;

    assign word_idx = dmem.addr[DMEM_AW+1:2];  // Word aligned

    always_ff @(posedge mem_debug_clk_gate) begin
        if (dmem.we) begin
            mem[word_idx] <= dmem.wdata;
        end
    end

    assign dmem.rdata = mem[word_idx];

endmodule

/* design/mips_load_store.sv */
`timescale 1ns/100ps

module mips_load_store import mips_pkg::*; (
    input  logic              mem_debug,
    input  logic              dbg_dm_we,
    input  logic [DATA_W-1:0] addr,
    input  logic [DATA_W-1:0] din,
    input  ctrl_t             ctrl,
    input  logic [DATA_W-1:0] alu_result,
    input  logic [DATA_W-1:0] rt_data,
    dmem_if.ctrl              dmem,
    output logic [DATA_W-1:0] load_data
);

    logic [DATA_W-1:0] st_word;
    logic [DATA_W-1:0] ld_ext;

    // SB/SH patch the low byte or half of the current word
    always_comb begin
        case (ctrl.mem_size)
            MEM_BYTE: st_word = {dmem.rdata[DATA_W-1:8], rt_data[7:0]};
            MEM_HALF: st_word = {dmem.rdata[DATA_W-1:16], rt_data[15:0]};
            default:  st_word = rt_data;
        endcase
    end

    always_comb begin
        case (ctrl.mem_size)
            MEM_BYTE: begin
                ld_ext = {{(DATA_W-8){ctrl.load_signed & dmem.rdata[7]}}, dmem.rdata[7:0]};
            end
            MEM_HALF: begin
                ld_ext = {{(DATA_W-16){ctrl.load_signed & dmem.rdata[15]}}, dmem.rdata[15:0]};
            end
            default:  ld_ext = dmem.rdata;
        endcase
    end

    assign dmem.addr  = mem_debug ? addr : alu_result;
    assign dmem.wdata = mem_debug ? din : st_word;
    assign dmem.we    = mem_debug ? dbg_dm_we : ctrl.mem_store;

    assign load_data  = mem_debug ? dmem.rdata : ld_ext;  // Raw word for debug readback

endmodule

/* design/mips_pc_unit.sv */
`timescale 1ns/100ps

module mips_pc_unit import mips_pkg::*; (
    input  logic              mem_debug_clk_gate,
    input  logic              HW_RSTn,
    input  logic              mem_debug,
    input  ctrl_t             ctrl,
    input  logic              cond,
    input  logic [15:0]       offset,
    input  logic [DATA_W-1:0] rs_data,
    output logic [DATA_W-1:0] pc
);

    logic              br_pend;  // Taken branch waiting for its delay slot
    logic [15:0]       br_off;
    logic [DATA_W-1:0] pc_next;

    always_comb begin
        if (br_pend) begin
            // pc here is the delay-slot instruction
            pc_next = pc + {{(DATA_W-18){br_off[15]}}, br_off, 2'b00};
        end else if (ctrl.jump_reg) begin
            pc_next = rs_data;
        end else begin
            pc_next = pc + DATA_W'(4);
        end
    end

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            pc      <= RESET_PC;
            br_pend <= 1'b0;
        end else if (mem_debug) begin
            pc      <= RESET_PC;  // Held while the back door is open
            br_pend <= 1'b0;
        end else begin
            pc      <= pc_next;
            br_pend <= ctrl.branch & cond;
        end
    end

    always_ff @(posedge mem_debug_clk_gate) begin
        if (!mem_debug && ctrl.branch) begin
            br_off <= offset;
        end
    end

    a_pc_aligned: assert property (@(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        pc[1:0] == 2'b00);

endmodule

/* design/mips_reg_file.sv */
`timescale 1ns/100ps

module mips_reg_file import mips_pkg::*; (
    input  logic                  mem_debug_clk_gate,
    input  logic                  HW_RSTn,
    input  logic [REG_ADDR_W-1:0] rs_addr,
    input  logic [REG_ADDR_W-1:0] rt_addr,
    input  logic [REG_ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0]     wr_data,
    input  logic                  wr_en,
    output logic [DATA_W-1:0]     rs_data,
    output logic [DATA_W-1:0]     rt_data
);

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge mem_debug_clk_gate or negedge HW_RSTn) begin
        if (!HW_RSTn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin  // $zero never written
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

    a_wr_addr_known: assert property (@(posedge mem_debug_clk_gate) disable iff (!HW_RSTn)
        wr_en |-> !$isunknown(wr_addr));

endmodule

/* design/mips_alu.sv */
`timescale 1ns/100ps

module mips_alu import mips_pkg::*; (
    input  alu_op_e           op,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic [DATA_W-1:0] result
);

    logic [4:0] sh_amt;

    assign sh_amt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_AND:    result = a & b;
            ALU_OR:     result = a | b;
            ALU_XOR:    result = a ^ b;
            ALU_NOR:    result = ~(a | b);
            ALU_SLL:    result = a << sh_amt;
            ALU_SRL:    result = a >> sh_amt;  // Logical, zero fill
            ALU_SLT: begin
                result = {{(DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
            end
            ALU_SLTU: begin
                result = {{(DATA_W-1){1'b0}}, a < b};
            end
            // Branch compare, only bit 0 matters to the PC
            ALU_EQ:     result = {{(DATA_W-1){1'b0}}, a == b};
            ALU_NEQ:    result = {{(DATA_W-1){1'b0}}, a != b};
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

/* design/mips_decoder.sv */
`timescale 1ns/100ps

module mips_decoder import mips_pkg::*; (
    input  mips_instr_u instr,
    output ctrl_t       ctrl
);

    always_comb begin
        ctrl = '0;  // Unsupported codes fall through with no write

        case (instr.r.opcode)
            OP_RTYPE: begin
                ctrl.reg_we = 1'b1;
                case (instr.r.funct)
                    FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:          ctrl.alu_op = ALU_AND;
                    FN_OR:           ctrl.alu_op = ALU_OR;
                    FN_XOR:          ctrl.alu_op = ALU_XOR;
                    FN_NOR:          ctrl.alu_op = ALU_NOR;
                    FN_SLT:          ctrl.alu_op = ALU_SLT;
                    FN_SLTU:         ctrl.alu_op = ALU_SLTU;
                    FN_SLL: begin
                        ctrl.alu_op    = ALU_SLL;
                        ctrl.use_shamt = 1'b1;
                    end
                    FN_SRL: begin
                        ctrl.alu_op    = ALU_SRL;
                        ctrl.use_shamt = 1'b1;
                    end
                    FN_JR: begin
                        ctrl.reg_we   = 1'b0;
                        ctrl.jump_reg = 1'b1;
                    end
                    default: ctrl.reg_we = 1'b0;
                endcase
            end

            OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                ctrl.reg_we    = 1'b1;
                ctrl.dst_is_rt = 1'b1;
                ctrl.imm_ext   = IMM_SIGN;
                ctrl.alu_op    = (instr.i.opcode == OP_ADDIU) ? ALU_ADD :
                                 (instr.i.opcode == OP_SLTI)  ? ALU_SLT : ALU_SLTU;
            end

            OP_ANDI, OP_ORI, OP_XORI: begin
                ctrl.reg_we    = 1'b1;
                ctrl.dst_is_rt = 1'b1;
                ctrl.imm_ext   = IMM_ZERO;  // Logical ops zero-extend
                ctrl.alu_op    = (instr.i.opcode == OP_ANDI) ? ALU_AND :
                                 (instr.i.opcode == OP_ORI)  ? ALU_OR : ALU_XOR;
            end

            OP_LUI: begin
                ctrl.reg_we    = 1'b1;
                ctrl.dst_is_rt = 1'b1;
                ctrl.imm_ext   = IMM_UPPER;
                ctrl.alu_op    = ALU_PASS_B;
            end

            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: begin
                ctrl.reg_we      = 1'b1;
                ctrl.dst_is_rt   = 1'b1;
                ctrl.imm_ext     = IMM_SIGN;
                ctrl.mem_load    = 1'b1;
                ctrl.load_signed = (instr.i.opcode == OP_LB) || (instr.i.opcode == OP_LH);
                ctrl.mem_size    = (instr.i.opcode == OP_LW) ? MEM_WORD :
                                   (instr.i.opcode == OP_LH || instr.i.opcode == OP_LHU) ?
                                   MEM_HALF : MEM_BYTE;
            end

            OP_SB, OP_SH, OP_SW: begin
                ctrl.imm_ext   = IMM_SIGN;
                ctrl.mem_store = 1'b1;
                ctrl.mem_size  = (instr.i.opcode == OP_SW) ? MEM_WORD :
                                 (instr.i.opcode == OP_SH) ? MEM_HALF : MEM_BYTE;
            end

            OP_BEQ, OP_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (instr.i.opcode == OP_BNE);
                ctrl.alu_op    = ctrl.branch_ne ? ALU_NEQ : ALU_EQ;  // Condition in bit 0
            end

            default: ;
        endcase
    end

endmodule

/* design/dmem_if.sv */
`timescale 1ns/100ps

interface dmem_if import mips_pkg::*; ();

    logic [DATA_W-1:0] addr;   // Byte address, low bits ignored
    logic [DATA_W-1:0] wdata;
    logic              we;
    logic [DATA_W-1:0] rdata;  // Combinational read

    modport ctrl (
        output addr, wdata, we,
        input  rdata
    );

    modport mem (
        input  addr, wdata, we,
        output rdata
    );

endinterface

/* design/mips_pkg.sv */
package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_DEPTH = 32;
    localparam int DMEM_DEPTH = 32;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);  // Word index bits
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
    localparam logic [DATA_W-1:0] RESET_PC = '0;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL,
        ALU_SRL, ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NEQ, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00, OP_BEQ  = 6'h04, OP_BNE  = 6'h05, OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b, OP_ANDI = 6'h0c, OP_ORI  = 6'h0d,
        OP_XORI  = 6'h0e, OP_LUI  = 6'h0f, OP_LB   = 6'h20, OP_LH    = 6'h21,
        OP_LW    = 6'h23, OP_LBU  = 6'h24, OP_LHU  = 6'h25, OP_SB    = 6'h28,
        OP_SH    = 6'h29, OP_SW   = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL = 6'h00, FN_SRL  = 6'h02, FN_JR  = 6'h08, FN_ADD = 6'h20,
        FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23, FN_AND = 6'h24,
        FN_OR  = 6'h25, FN_XOR  = 6'h26, FN_NOR = 6'h27, FN_SLT = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [1:0] {IMM_REG, IMM_SIGN, IMM_ZERO, IMM_UPPER} imm_ext_e;
    typedef enum logic [1:0] {MEM_NONE, MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;
    typedef enum logic {WB_ALU, WB_LOAD} wb_sel_e;
    typedef enum logic [1:0] {DBG_NONE, DBG_IM, DBG_DM, DBG_MR} debug_target_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [REG_ADDR_W-1:0]  rs;
        logic [REG_ADDR_W-1:0]  rt;
        logic [REG_ADDR_W-1:0]  rd;
        logic [4:0]             shamt;
        funct_e                 funct;
    } r_instr_t;

    typedef struct packed {
        opcode_e                opcode;
        logic [REG_ADDR_W-1:0]  rs;
        logic [REG_ADDR_W-1:0]  rt;
        logic [15:0]            imm16;
    } i_instr_t;

    // Same word, two field layouts
    typedef union packed {
        r_instr_t r;
        i_instr_t i;
    } mips_instr_u;

    typedef struct packed {
        logic       reg_we;
        alu_op_e    alu_op;
        imm_ext_e   imm_ext;
        logic       use_shamt;    // SLL/SRL take shamt
        logic       dst_is_rt;    // I-type writes rt
        mem_size_e  mem_size;
        logic       mem_load;
        logic       mem_store;
        logic       load_signed;
        logic       branch;
        logic       branch_ne;
        logic       jump_reg;
    } ctrl_t;

endpackage
